// File: Makefile
TOP := tb_dispatch
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f sources.f

sim:
	verilator --binary --timing --top-module $(TOP) -f sources.f -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -qx "Regression passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: common/datapath_pkg.sv
`default_nettype none

`include "dispatch_defines.svh"

package datapath_pkg;

    // functional unit class
    typedef enum logic [1:0] {
        FU_T_NONE,
        FU_T_S,
        FU_T_M,
        FU_T_G
    } fu_t_e;

    typedef enum logic [1:0] {
        FU_S_NONE,
        FU_S_ALU,
        FU_S_LD_ST,
        FU_S_BRANCH
    } fu_s_e;

    typedef enum logic [1:0] {
        FU_M_NONE,
        FU_M_LD_ST,
        FU_M_GEMM
    } fu_m_e;

    typedef struct packed {
        fu_t_e                  fu_t;
        fu_s_e                  fu_s;
        fu_m_e                  fu_m;
        logic [`WORD_W-1:0]     imm;
        isa_pkg::alu_op_t       alu_op;
        isa_pkg::branch_op_t    branch_op;
        isa_pkg::mem_type_t     s_mem_type;
        isa_pkg::mem_type_t     m_mem_type;
        logic                   s_reg_write;
        logic                   m_reg_write;
        logic [`M_IDX_W-1:0]    m_rd;
    } cu_ctrl_t;

    // busy implies a nonzero tag
    typedef struct packed {
        logic              busy;
        logic [`TAG_W-1:0] tag;
    } rst_entry_t;

    typedef struct packed {
        logic s_alu;
        logic s_ldst;
        logic s_branch;
        logic m_ldst;
        logic gemm;
    } fu_busy_t;

    // writeback commits
    typedef struct packed {
        logic                s_en;
        logic [`S_IDX_W-1:0] s_idx;
        logic                m_en;
        logic [`M_IDX_W-1:0] m_idx;
    } wb_t;

    typedef struct packed {
        logic [`S_IDX_W-1:0] rd;
        logic [`S_IDX_W-1:0] rs1;
        logic [`S_IDX_W-1:0] rs2;
        logic [`WORD_W-1:0]  imm;
        logic [`TAG_W-1:0]   t1;
        logic [`TAG_W-1:0]   t2;
    } fust_s_t;

    // matrix load/store, address comes from scalar registers
    typedef struct packed {
        logic [`M_IDX_W-1:0] rd;
        logic [`S_IDX_W-1:0] rs1;
        logic [`S_IDX_W-1:0] rs2;
        logic [10:0]         imm;
        logic [`TAG_W-1:0]   t1;
        logic [`TAG_W-1:0]   t2;
    } fust_m_t;

    typedef struct packed {
        logic [`M_IDX_W-1:0] rd;
        logic [`M_IDX_W-1:0] ms1;
        logic [`M_IDX_W-1:0] ms2;
        logic [`M_IDX_W-1:0] ms3;
        logic [`TAG_W-1:0]   t1;
        logic [`TAG_W-1:0]   t2;
        logic [`TAG_W-1:0]   t3;
    } fust_g_t;

    typedef struct packed {
        logic [`WORD_W-1:0]  imm;
        isa_pkg::alu_op_t    alu_op;
        isa_pkg::branch_op_t branch_op;
        isa_pkg::mem_type_t  s_mem_type;
        isa_pkg::mem_type_t  m_mem_type;
        logic [`M_IDX_W-1:0] m_rw;
        logic                m_rw_en;
    } ex_ctrl_t;

    typedef struct packed {
        logic                s_rw_en;
        logic [`S_IDX_W-1:0] s_rw;
    } wb_ctrl_t;

    typedef struct packed {
        fu_s_e    fu_s;
        fu_m_e    fu_m;
        ex_ctrl_t ex_ctrl;
        wb_ctrl_t wb_ctrl;
    } dispatch_t;

endpackage

`default_nettype wire

// File: common/dispatch_defines.svh
`ifndef DISPATCH_DEFINES_SVH
`define DISPATCH_DEFINES_SVH

// instruction word and immediate width
`define WORD_W 32

// architectural register counts
`define S_REGS 32
`define M_REGS 16

// register index widths
`define S_IDX_W 5
`define M_IDX_W 4

// producer tag width and tag values
`define TAG_W 2
`define TAG_READY 2'd0
`define TAG_EXEC 2'd1
`define TAG_LOAD 2'd2

`endif

// File: common/isa_pkg.sv
`default_nettype none

`include "dispatch_defines.svh"

package isa_pkg;

    // major opcodes, scalar side follows RV32I
    typedef enum logic [6:0] {
        OP_R_ALU  = 7'b0110011,
        OP_I_ALU  = 7'b0010011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011,
        OP_MLOAD  = 7'b0000111,
        OP_MSTORE = 7'b0100111,
        OP_GEMM   = 7'b1110111
    } opcode_t;

    // scalar view of the instruction word
    typedef struct packed {
        logic [6:0]          funct7;
        logic [`S_IDX_W-1:0] rs2;
        logic [`S_IDX_W-1:0] rs1;
        logic [2:0]          funct3;
        logic [`S_IDX_W-1:0] rd;
        opcode_t             opcode;
    } s_fields_t;

    // matrix view, spare bits carry the load/store offset
    typedef struct packed {
        logic [`M_IDX_W-1:0] md;
        logic [`M_IDX_W-1:0] ms1;
        logic [`M_IDX_W-1:0] ms2;
        logic [`M_IDX_W-1:0] ms3;
        logic [8:0]          spare;
        opcode_t             opcode;
    } m_fields_t;

    typedef union packed {
        s_fields_t s;
        m_fields_t m;
    } instr_u;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU
    } alu_op_t;

    // encoded as funct3 so the decoder can pass it straight through
    typedef enum logic [2:0] {
        BR_EQ  = 3'b000,
        BR_NE  = 3'b001,
        BR_LT  = 3'b100,
        BR_GE  = 3'b101,
        BR_LTU = 3'b110,
        BR_GEU = 3'b111
    } branch_op_t;

    typedef enum logic [1:0] {
        MEM_NONE,
        MEM_LOAD,
        MEM_STORE
    } mem_type_t;

endpackage

`default_nettype wire

// File: dispatch/control_unit.sv
`default_nettype none

`include "dispatch_defines.svh"

module control_unit (
    input  wire isa_pkg::instr_u     instr,
    output datapath_pkg::cu_ctrl_t   ctrl
);

    isa_pkg::s_fields_t s;
    isa_pkg::m_fields_t m;
    logic [`WORD_W-1:0] imm_i;
    logic [`WORD_W-1:0] imm_s;
    logic [`WORD_W-1:0] imm_b;
    isa_pkg::alu_op_t   alu_dec;

    assign s = instr.s;
    assign m = instr.m;

    // immediate formats from the scalar view
    assign imm_i = {{(`WORD_W-12){s.funct7[6]}}, s.funct7, s.rs2};
    assign imm_s = {{(`WORD_W-12){s.funct7[6]}}, s.funct7, s.rd};
    assign imm_b = {{(`WORD_W-13){s.funct7[6]}}, s.funct7[6], s.rd[0],
                    s.funct7[5:0], s.rd[4:1], 1'b0};

    // funct3/funct7 to alu op, sub only exists for register form
    always_comb begin
        case (s.funct3)
            3'b000: begin
                if (s.opcode == isa_pkg::OP_R_ALU && s.funct7[5]) begin
                    alu_dec = isa_pkg::ALU_SUB;
                end else begin
                    alu_dec = isa_pkg::ALU_ADD;
                end
            end
            3'b001: alu_dec = isa_pkg::ALU_SLL;
            3'b010: alu_dec = isa_pkg::ALU_SLT;
            3'b011: alu_dec = isa_pkg::ALU_SLTU;
            3'b100: alu_dec = isa_pkg::ALU_XOR;
            3'b101: alu_dec = s.funct7[5] ? isa_pkg::ALU_SRA : isa_pkg::ALU_SRL;
            3'b110: alu_dec = isa_pkg::ALU_OR;
            default: alu_dec = isa_pkg::ALU_AND;
        endcase
    end

    always_comb begin
        ctrl = '0;
        ctrl.m_rd = m.md;
        case (s.opcode)
            isa_pkg::OP_R_ALU, isa_pkg::OP_I_ALU: begin
                ctrl.fu_t        = datapath_pkg::FU_T_S;
                ctrl.fu_s        = datapath_pkg::FU_S_ALU;
                ctrl.alu_op      = alu_dec;
                ctrl.imm         = (s.opcode == isa_pkg::OP_I_ALU) ? imm_i : '0;
                ctrl.s_reg_write = (s.rd != '0);
            end
            isa_pkg::OP_LOAD: begin
                ctrl.fu_t        = datapath_pkg::FU_T_S;
                ctrl.fu_s        = datapath_pkg::FU_S_LD_ST;
                ctrl.imm         = imm_i;
                ctrl.s_mem_type  = isa_pkg::MEM_LOAD;
                ctrl.s_reg_write = (s.rd != '0);
            end
            isa_pkg::OP_STORE: begin
                ctrl.fu_t       = datapath_pkg::FU_T_S;
                ctrl.fu_s       = datapath_pkg::FU_S_LD_ST;
                ctrl.imm        = imm_s;
                ctrl.s_mem_type = isa_pkg::MEM_STORE;
            end
            isa_pkg::OP_BRANCH: begin
                ctrl.fu_t      = datapath_pkg::FU_T_S;
                ctrl.fu_s      = datapath_pkg::FU_S_BRANCH;
                ctrl.imm       = imm_b;
                ctrl.alu_op    = isa_pkg::ALU_SUB;
                ctrl.branch_op = isa_pkg::branch_op_t'(s.funct3);
            end
            isa_pkg::OP_MLOAD, isa_pkg::OP_MSTORE: begin
                ctrl.fu_t = datapath_pkg::FU_T_M;
                ctrl.fu_m = datapath_pkg::FU_M_LD_ST;
                // offset is the zero-extended spare field
                ctrl.imm  = {{(`WORD_W-9){1'b0}}, m.spare};
                if (s.opcode == isa_pkg::OP_MLOAD) begin
                    ctrl.m_mem_type  = isa_pkg::MEM_LOAD;
                    ctrl.m_reg_write = 1'b1;
                end else begin
                    ctrl.m_mem_type = isa_pkg::MEM_STORE;
                end
            end
            isa_pkg::OP_GEMM: begin
                ctrl.fu_t        = datapath_pkg::FU_T_G;
                ctrl.fu_m        = datapath_pkg::FU_M_GEMM;
                ctrl.m_reg_write = 1'b1;
            end
            default: begin
                // unknown opcode, class none and no writes
                ctrl.m_rd = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: dispatch/dispatch.sv
`default_nettype none

`include "dispatch_defines.svh"

module dispatch (
    input  wire logic                  CLK,
    input  wire logic                  nRST,
    input  wire isa_pkg::instr_u       instr,
    input  wire logic                  ihit,
    input  wire logic                  flush,
    input  wire logic                  freeze,
    input  wire datapath_pkg::fu_busy_t fu_busy,
    input  wire datapath_pkg::wb_t     wb,

    output datapath_pkg::dispatch_t    out,
    output logic                       stall,
    output datapath_pkg::fu_s_e        fu_s,
    output logic                       fust_s_en,
    output datapath_pkg::fust_s_t      fust_s,
    output logic                       fust_m_en,
    output datapath_pkg::fust_m_t      fust_m,
    output logic                       fust_g_en,
    output datapath_pkg::fust_g_t      fust_g
);

    datapath_pkg::cu_ctrl_t                    ctrl;
    datapath_pkg::rst_entry_t [`S_REGS-1:0]    s_status;
    datapath_pkg::rst_entry_t [`M_REGS-1:0]    m_status;
    datapath_pkg::dispatch_t                   record;
    datapath_pkg::dispatch_t                   out_next;

    logic                kill;
    logic                unit_busy;
    logic                waw;
    logic                hazard;
    logic                go;
    logic                s_set_en;
    logic                m_set_en;
    logic [`TAG_W-1:0]   s_set_tag;
    logic [`TAG_W-1:0]   m_set_tag;

    control_unit i_control_unit (
        .instr (instr),
        .ctrl  (ctrl)
    );

    reg_status_table #(
        .NREGS (`S_REGS),
        .IDX_W (`S_IDX_W)
    ) i_rst_s (
        .CLK     (CLK),
        .nRST    (nRST),
        .set_en  (s_set_en),
        .set_sel (instr.s.rd),
        .set_tag (s_set_tag),
        .clr_en  (wb.s_en),
        .clr_sel (wb.s_idx),
        .status  (s_status)
    );

    reg_status_table #(
        .NREGS (`M_REGS),
        .IDX_W (`M_IDX_W)
    ) i_rst_m (
        .CLK     (CLK),
        .nRST    (nRST),
        .set_en  (m_set_en),
        .set_sel (instr.m.md),
        .set_tag (m_set_tag),
        .clr_en  (wb.m_en),
        .clr_sel (wb.m_idx),
        .status  (m_status)
    );

    // flush only counts when fetch actually delivered something
    assign kill = flush & ihit;

    // structural hazard on the unit this instruction needs
    always_comb begin
        case (ctrl.fu_t)
            datapath_pkg::FU_T_S: begin
                case (ctrl.fu_s)
                    datapath_pkg::FU_S_ALU:    unit_busy = fu_busy.s_alu;
                    datapath_pkg::FU_S_LD_ST:  unit_busy = fu_busy.s_ldst;
                    datapath_pkg::FU_S_BRANCH: unit_busy = fu_busy.s_branch;
                    default:                   unit_busy = 1'b0;
                endcase
            end
            datapath_pkg::FU_T_M: unit_busy = fu_busy.m_ldst;
            datapath_pkg::FU_T_G: unit_busy = fu_busy.gemm;
            default:              unit_busy = 1'b0;
        endcase
    end

    // WAW against the table this instruction writes
    assign waw = (ctrl.m_reg_write & m_status[instr.m.md].busy) |
                 (ctrl.s_reg_write & s_status[instr.s.rd].busy);

    assign hazard = unit_busy | waw;
    assign stall  = hazard & ~kill;
    assign go     = (ctrl.fu_t != datapath_pkg::FU_T_NONE) & ~kill & ~freeze & ~hazard;

    // mark destinations pending, loads get their own tag
    assign s_set_en  = go & ctrl.s_reg_write;
    assign m_set_en  = go & ctrl.m_reg_write;
    assign s_set_tag = (ctrl.fu_s == datapath_pkg::FU_S_LD_ST) ? `TAG_LOAD : `TAG_EXEC;
    assign m_set_tag = (ctrl.fu_m == datapath_pkg::FU_M_LD_ST) ? `TAG_LOAD : `TAG_EXEC;

    // issue to the status tables in the same cycle
    assign fu_s      = ctrl.fu_s;
    assign fust_s_en = go & (ctrl.fu_t == datapath_pkg::FU_T_S);
    assign fust_m_en = go & (ctrl.fu_t == datapath_pkg::FU_T_M);
    assign fust_g_en = go & (ctrl.fu_t == datapath_pkg::FU_T_G);

    always_comb begin
        fust_s.rd  = instr.s.rd;
        fust_s.rs1 = instr.s.rs1;
        fust_s.rs2 = instr.s.rs2;
        fust_s.imm = ctrl.imm;
        fust_s.t1  = s_status[instr.s.rs1].tag;
        fust_s.t2  = s_status[instr.s.rs2].tag;

        // matrix load/store takes its address operands from the scalar side
        fust_m.rd  = instr.m.md;
        fust_m.rs1 = instr.s.rs1;
        fust_m.rs2 = instr.s.rs2;
        fust_m.imm = ctrl.imm[10:0];
        fust_m.t1  = s_status[instr.s.rs1].tag;
        fust_m.t2  = s_status[instr.s.rs2].tag;

        fust_g.rd  = instr.m.md;
        fust_g.ms1 = instr.m.ms1;
        fust_g.ms2 = instr.m.ms2;
        fust_g.ms3 = instr.m.ms3;
        fust_g.t1  = m_status[instr.m.ms1].tag;
        fust_g.t2  = m_status[instr.m.ms2].tag;
        fust_g.t3  = m_status[instr.m.ms3].tag;
    end

    // record handed to execute and writeback
    always_comb begin
        record.fu_s               = ctrl.fu_s;
        record.fu_m               = ctrl.fu_m;
        record.ex_ctrl.imm        = ctrl.imm;
        record.ex_ctrl.alu_op     = ctrl.alu_op;
        record.ex_ctrl.branch_op  = ctrl.branch_op;
        record.ex_ctrl.s_mem_type = ctrl.s_mem_type;
        record.ex_ctrl.m_mem_type = ctrl.m_mem_type;
        record.ex_ctrl.m_rw       = ctrl.m_rd;
        record.ex_ctrl.m_rw_en    = ctrl.m_reg_write;
        record.wb_ctrl.s_rw_en    = ctrl.s_reg_write;
        record.wb_ctrl.s_rw       = instr.s.rd;
    end

    // kill, then freeze, then bubble on hazard
    always_comb begin
        if (kill) begin
            out_next = '0;
        end else if (freeze) begin
            out_next = out;
        end else if (hazard) begin
            out_next = '0;
        end else begin
            out_next = record;
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            out <= '0;
        end else begin
            out <= out_next;
        end
    end

endmodule

`default_nettype wire

// File: dispatch/reg_status_table.sv
`default_nettype none

`include "dispatch_defines.svh"

module reg_status_table #(
    parameter int NREGS = 32,
    parameter int IDX_W = 5
) (
    input  wire logic                                  CLK,
    input  wire logic                                  nRST,

    // dispatch marks a destination pending
    input  wire logic                                  set_en,
    input  wire logic [IDX_W-1:0]                      set_sel,
    input  wire logic [`TAG_W-1:0]                     set_tag,

    // writeback commit releases it
    input  wire logic                                  clr_en,
    input  wire logic [IDX_W-1:0]                      clr_sel,

    output datapath_pkg::rst_entry_t [NREGS-1:0]       status
);

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            status <= '0;
        end else begin
            if (clr_en) begin
                status[clr_sel].busy <= 1'b0;
                status[clr_sel].tag  <= `TAG_READY;
            end
            // later assignment so a same-cycle set beats the clear
            if (set_en) begin
                status[set_sel].busy <= 1'b1;
                status[set_sel].tag  <= set_tag;
            end
        end
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+common
+incdir+tb
common/isa_pkg.sv
common/datapath_pkg.sv
dispatch/control_unit.sv
dispatch/reg_status_table.sv
dispatch/dispatch.sv
tb/tb_dispatch.sv

// File: tb/dispatch_tests.svh
`ifndef DISPATCH_TESTS_SVH
`define DISPATCH_TESTS_SVH

// RV32 style instruction encoders
function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3,
                                       input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, isa_pkg::OP_R_ALU};
endfunction

function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
                                       input logic [2:0] f3, input logic [4:0] rd,
                                       input isa_pkg::opcode_t op);
    return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] s_word(input logic [11:0] imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], isa_pkg::OP_STORE};
endfunction

function automatic logic [31:0] b_word(input logic [12:0] imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], isa_pkg::OP_BRANCH};
endfunction

// matrix words put md/ms1/ms2/ms3 in the top nibbles
function automatic logic [31:0] m_word(input logic [3:0] md, input logic [3:0] ms1,
                                       input logic [3:0] ms2, input logic [3:0] ms3,
                                       input isa_pkg::opcode_t op);
    return {md, ms1, ms2, ms3, 9'd0, op};
endfunction

function automatic logic [4:0] scalar_index();
    return 5'($urandom_range(31, 1));
endfunction

function automatic logic [3:0] matrix_index();
    return 4'($urandom_range(15, 0));
endfunction

// drives one scalar word and checks issue now and the record after the edge
task automatic issue_scalar(input logic [31:0] word, input datapath_pkg::fu_s_e unit,
                            input logic [31:0] imm_exp, input isa_pkg::mem_type_t mem,
                            input logic [3:0] op_exp, input logic writes);
    logic [4:0] rd;
    rd    = word[11:7];
    instr = word;
    settle();
    expect_enables(1'b1, 1'b0, 1'b0, 1'b0);
    check("fu_s", 64'(unit), 64'(fu_s));
    check("fust_s.rd", 64'(rd), 64'(fust_s.rd));
    check("fust_s.rs1", 64'(word[19:15]), 64'(fust_s.rs1));
    check("fust_s.rs2", 64'(word[24:20]), 64'(fust_s.rs2));
    check("fust_s.imm", 64'(imm_exp), 64'(fust_s.imm));
    tick();
    check("out.fu_s", 64'(unit), 64'(out.fu_s));
    check("out.imm", 64'(imm_exp), 64'(out.ex_ctrl.imm));
    check("out.s_mem_type", 64'(mem), 64'(out.ex_ctrl.s_mem_type));
    check("out.s_rw_en", 64'(writes), 64'(out.wb_ctrl.s_rw_en));
    if (writes) begin
        check("out.s_rw", 64'(rd), 64'(out.wb_ctrl.s_rw));
    end
    if (unit == datapath_pkg::FU_S_ALU) begin
        check("out.alu_op", 64'(op_exp), 64'(out.ex_ctrl.alu_op));
    end
    if (unit == datapath_pkg::FU_S_BRANCH) begin
        check("out.branch_op", 64'(op_exp), 64'(out.ex_ctrl.branch_op));
    end
    // free the destination again
    commit(writes, rd, 1'b0, 4'd0);
endtask

task automatic reset_and_bubble();
    cur_test = "reset_and_bubble";
    check("out after reset", 64'd0, 64'(out));
    settle();
    expect_enables(1'b0, 1'b0, 1'b0, 1'b0);
    tick();
    instr = {25'($urandom), 7'b1111111};
    settle();
    expect_enables(1'b0, 1'b0, 1'b0, 1'b0);
    tick();
    check("out.fu_s", 64'(datapath_pkg::FU_S_NONE), 64'(out.fu_s));
    check("out.fu_m", 64'(datapath_pkg::FU_M_NONE), 64'(out.fu_m));
    check("out.s_rw_en", 64'd0, 64'(out.wb_ctrl.s_rw_en));
    check("out.m_rw_en", 64'd0, 64'(out.ex_ctrl.m_rw_en));
    instr = '0;
endtask

task automatic scalar_decode();
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [11:0] imm12;
    logic [12:0] imm13;
    cur_test = "scalar_issue";
    rd    = scalar_index();
    rs1   = scalar_index();
    rs2   = scalar_index();
    imm12 = 12'($urandom);
    imm13 = {12'($urandom), 1'b0};
    issue_scalar(r_word(7'b0100000, rs2, rs1, 3'b000, rd), datapath_pkg::FU_S_ALU, 32'd0,
                 isa_pkg::MEM_NONE, 4'(isa_pkg::ALU_SUB), 1'b1);
    issue_scalar(i_word(imm12, rs1, 3'b100, rd, isa_pkg::OP_I_ALU), datapath_pkg::FU_S_ALU,
                 {{20{imm12[11]}}, imm12}, isa_pkg::MEM_NONE, 4'(isa_pkg::ALU_XOR), 1'b1);
    issue_scalar(i_word(imm12, rs1, 3'b010, rd, isa_pkg::OP_LOAD), datapath_pkg::FU_S_LD_ST,
                 {{20{imm12[11]}}, imm12}, isa_pkg::MEM_LOAD, 4'd0, 1'b1);
    issue_scalar(s_word(imm12, rs2, rs1, 3'b010), datapath_pkg::FU_S_LD_ST,
                 {{20{imm12[11]}}, imm12}, isa_pkg::MEM_STORE, 4'd0, 1'b0);
    issue_scalar(b_word(imm13, rs2, rs1, 3'b001), datapath_pkg::FU_S_BRANCH,
                 {{19{imm13[12]}}, imm13}, isa_pkg::MEM_NONE, 4'(isa_pkg::BR_NE), 1'b0);
endtask

task automatic matrix_decode();
    logic [3:0] md;
    logic [3:0] ms1;
    logic [3:0] ms2;
    logic [3:0] ms3;
    logic [4:0] rs1;
    logic [4:0] rs2;
    cur_test = "matrix_issue";
    md  = matrix_index();
    ms1 = matrix_index();
    ms2 = matrix_index();
    ms3 = matrix_index();
    rs1 = scalar_index();
    rs2 = scalar_index();
    // mload keeps its address registers in the scalar rs1/rs2 slots
    instr = {md, 3'b000, rs2, rs1, 3'b000, 5'd0, isa_pkg::OP_MLOAD};
    settle();
    expect_enables(1'b0, 1'b1, 1'b0, 1'b0);
    check("fust_m.rd", 64'(md), 64'(fust_m.rd));
    check("fust_m.rs1", 64'(rs1), 64'(fust_m.rs1));
    check("fust_m.rs2", 64'(rs2), 64'(fust_m.rs2));
    tick();
    check("out.fu_m", 64'(datapath_pkg::FU_M_LD_ST), 64'(out.fu_m));
    check("out.m_mem_type", 64'(isa_pkg::MEM_LOAD), 64'(out.ex_ctrl.m_mem_type));
    check("out.m_rw", 64'(md), 64'(out.ex_ctrl.m_rw));
    check("out.m_rw_en", 64'd1, 64'(out.ex_ctrl.m_rw_en));
    commit(1'b0, 5'd0, 1'b1, md);
    instr = m_word(md, ms1, ms2, ms3, isa_pkg::OP_GEMM);
    settle();
    expect_enables(1'b0, 1'b0, 1'b1, 1'b0);
    check("fust_g.rd", 64'(md), 64'(fust_g.rd));
    check("fust_g.ms1", 64'(ms1), 64'(fust_g.ms1));
    check("fust_g.ms2", 64'(ms2), 64'(fust_g.ms2));
    check("fust_g.ms3", 64'(ms3), 64'(fust_g.ms3));
    tick();
    check("out.fu_m", 64'(datapath_pkg::FU_M_GEMM), 64'(out.fu_m));
    check("out.m_rw", 64'(md), 64'(out.ex_ctrl.m_rw));
    check("out.m_rw_en", 64'd1, 64'(out.ex_ctrl.m_rw_en));
    commit(1'b0, 5'd0, 1'b1, md);
endtask

task automatic tag_tracking();
    logic [4:0] r;
    logic [3:0] a;
    logic [3:0] b;
    logic [3:0] c;
    cur_test = "tags";
    r = scalar_index();
    a = matrix_index();
    b = a + 4'd1;
    c = a + 4'd2;
    instr = i_word(12'h010, 5'd0, 3'b010, r, isa_pkg::OP_LOAD);
    settle();
    expect_enables(1'b1, 1'b0, 1'b0, 1'b0);
    tick();
    // reader with rd x0 leaves no pending entry behind
    instr = r_word(7'd0, 5'd0, r, 3'b000, 5'd0);
    settle();
    check("t1 after load", 64'(`TAG_LOAD), 64'(fust_s.t1));
    check("t2 idle", 64'(`TAG_READY), 64'(fust_s.t2));
    tick();
    // matrix store takes its address from the pending scalar register
    instr = {4'd0, 3'b000, 5'd0, r, 3'd5, 5'd9, isa_pkg::OP_MSTORE};
    settle();
    expect_enables(1'b0, 1'b1, 1'b0, 1'b0);
    check("mstore t1 after load", 64'(`TAG_LOAD), 64'(fust_m.t1));
    check("mstore t2 idle", 64'(`TAG_READY), 64'(fust_m.t2));
    // the spare field holds the offset and shares its top bit with rs1
    check("mstore offset", 64'({2'b00, r[0], 3'd5, 5'd9}), 64'(fust_m.imm));
    tick();
    commit(1'b1, r, 1'b0, 4'd0);
    instr = r_word(7'd0, 5'd0, r, 3'b000, 5'd0);
    settle();
    check("t1 after writeback", 64'(`TAG_READY), 64'(fust_s.t1));
    tick();
    instr = m_word(a, 4'd0, 4'd0, 4'd0, isa_pkg::OP_MLOAD);
    settle();
    expect_enables(1'b0, 1'b1, 1'b0, 1'b0);
    tick();
    instr = m_word(b, a, c, c, isa_pkg::OP_GEMM);
    settle();
    expect_enables(1'b0, 1'b0, 1'b1, 1'b0);
    check("gemm t1 after mload", 64'(`TAG_LOAD), 64'(fust_g.t1));
    check("gemm t2 idle", 64'(`TAG_READY), 64'(fust_g.t2));
    tick();
    commit(1'b0, 5'd0, 1'b1, a);
    // b is now pending from the first gemm
    instr = m_word(c, a, b, a, isa_pkg::OP_GEMM);
    settle();
    check("gemm t1 after writeback", 64'(`TAG_READY), 64'(fust_g.t1));
    check("gemm t2 from gemm", 64'(`TAG_EXEC), 64'(fust_g.t2));
    check("gemm t3", 64'(`TAG_READY), 64'(fust_g.t3));
    tick();
    commit(1'b0, 5'd0, 1'b1, b);
    commit(1'b0, 5'd0, 1'b1, c);
endtask

task automatic hazard_stall();
    logic [4:0] r;
    cur_test = "hazards";
    r = scalar_index();
    fu_busy.s_alu = 1'b1;
    instr = i_word(12'h005, 5'd0, 3'b000, r, isa_pkg::OP_I_ALU);
    settle();
    expect_enables(1'b0, 1'b0, 1'b0, 1'b1);
    tick();
    check("out on busy unit", 64'd0, 64'(out));
    fu_busy.s_alu = 1'b0;
    settle();
    expect_enables(1'b1, 1'b0, 1'b0, 1'b0);
    tick();
    check("out.s_rw", 64'(r), 64'(out.wb_ctrl.s_rw));
    // same word again is a WAW on r
    settle();
    expect_enables(1'b0, 1'b0, 1'b0, 1'b1);
    tick();
    check("out on waw", 64'd0, 64'(out));
    wb.s_en  = 1'b1;
    wb.s_idx = r;
    settle();
    expect_enables(1'b0, 1'b0, 1'b0, 1'b1);
    tick();
    wb = '0;
    settle();
    expect_enables(1'b1, 1'b0, 1'b0, 1'b0);
    tick();
    check("out.s_rw_en", 64'd1, 64'(out.wb_ctrl.s_rw_en));
    commit(1'b1, r, 1'b0, 4'd0);
    fu_busy.gemm = 1'b1;
    instr = m_word(4'd3, 4'd1, 4'd2, 4'd4, isa_pkg::OP_GEMM);
    settle();
    expect_enables(1'b0, 1'b0, 1'b0, 1'b1);
    tick();
    fu_busy = '0;
    instr   = '0;
endtask

task automatic flush_and_freeze();
    logic [4:0]              r;
    logic [4:0]              q;
    datapath_pkg::dispatch_t held;
    cur_test = "flush_freeze";
    r = scalar_index();
    q = (r == 5'd31) ? 5'd1 : r + 5'd1;
    flush = 1'b1;
    instr = i_word(12'h07f, 5'd0, 3'b110, r, isa_pkg::OP_I_ALU);
    settle();
    expect_enables(1'b0, 1'b0, 1'b0, 1'b0);
    tick();
    check("out on flush", 64'd0, 64'(out));
    ihit = 1'b0;
    settle();
    expect_enables(1'b1, 1'b0, 1'b0, 1'b0);
    tick();
    flush = 1'b0;
    ihit  = 1'b1;
    check("out.s_rw", 64'(r), 64'(out.wb_ctrl.s_rw));
    held = out;
    // frozen word writes q and reads r while r is retired
    freeze   = 1'b1;
    wb.s_en  = 1'b1;
    wb.s_idx = r;
    instr    = i_word(12'h001, r, 3'b000, q, isa_pkg::OP_I_ALU);
    settle();
    expect_enables(1'b0, 1'b0, 1'b0, 1'b0);
    check("t1 before writeback", 64'(`TAG_EXEC), 64'(fust_s.t1));
    tick();
    check("out held", 64'(held), 64'(out));
    wb = '0;
    settle();
    check("t1 after frozen writeback", 64'(`TAG_READY), 64'(fust_s.t1));
    tick();
    check("out still held", 64'(held), 64'(out));
    freeze = 1'b0;
    instr  = r_word(7'd0, r, q, 3'b000, 5'd0);
    settle();
    expect_enables(1'b1, 1'b0, 1'b0, 1'b0);
    check("q never set", 64'(`TAG_READY), 64'(fust_s.t1));
    check("r released", 64'(`TAG_READY), 64'(fust_s.t2));
    tick();
    instr = '0;
endtask

`endif

// File: tb/tb_dispatch.sv
`default_nettype none

`include "dispatch_defines.svh"

module tb_dispatch;

    localparam int PERIOD       = 8;
    localparam int RESET_CYCLES = 5;
    localparam int NUM_TESTS    = 6;
    // cycles allowed for each test
    localparam int TEST_CYCLES  = 60;
    localparam int TIMEOUT      = (RESET_CYCLES + NUM_TESTS * TEST_CYCLES) * PERIOD;

    logic                    CLK;
    logic                    nRST;
    logic [31:0]             instr;
    logic                    ihit;
    logic                    flush;
    logic                    freeze;
    datapath_pkg::fu_busy_t  fu_busy;
    datapath_pkg::wb_t       wb;

    datapath_pkg::dispatch_t out;
    logic                    stall;
    datapath_pkg::fu_s_e     fu_s;
    logic                    fust_s_en;
    datapath_pkg::fust_s_t   fust_s;
    logic                    fust_m_en;
    datapath_pkg::fust_m_t   fust_m;
    logic                    fust_g_en;
    datapath_pkg::fust_g_t   fust_g;

    string                   cur_test;

    dispatch i_dispatch (
        .CLK       (CLK),
        .nRST      (nRST),
        .instr     (instr),
        .ihit      (ihit),
        .flush     (flush),
        .freeze    (freeze),
        .fu_busy   (fu_busy),
        .wb        (wb),
        .out       (out),
        .stall     (stall),
        .fu_s      (fu_s),
        .fust_s_en (fust_s_en),
        .fust_s    (fust_s),
        .fust_m_en (fust_m_en),
        .fust_m    (fust_m),
        .fust_g_en (fust_g_en),
        .fust_g    (fust_g)
    );

    initial begin
        CLK = 1'b0;
    end

    always #(PERIOD / 2) CLK = ~CLK;

    task automatic check(input string label, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (expected !== actual) begin
            $display("ERROR %s %s: expected %0h, actual %0h", cur_test, label, expected, actual);
            $display("Regression failed");
            $fatal(1, "value mismatch in test %s", cur_test);
        end
    endtask

    // advance to one time unit past the next rising edge
    task automatic tick();
        @(posedge CLK);
        #1;
    endtask

    // let combinational outputs follow the new inputs
    task automatic settle();
        #1;
    endtask

    task automatic idle_inputs();
        instr   = '0;
        ihit    = 1'b1;
        flush   = 1'b0;
        freeze  = 1'b0;
        fu_busy = '0;
        wb      = '0;
    endtask

    task automatic expect_enables(input logic s_en, input logic m_en, input logic g_en,
                                  input logic stall_exp);
        check("fust_s_en", 64'(s_en), 64'(fust_s_en));
        check("fust_m_en", 64'(m_en), 64'(fust_m_en));
        check("fust_g_en", 64'(g_en), 64'(fust_g_en));
        check("stall", 64'(stall_exp), 64'(stall));
    endtask

    // one-cycle writeback commit with an idle instruction
    task automatic commit(input logic s_en, input logic [4:0] s_idx,
                          input logic m_en, input logic [3:0] m_idx);
        instr    = '0;
        wb.s_en  = s_en;
        wb.s_idx = s_idx;
        wb.m_en  = m_en;
        wb.m_idx = m_idx;
        tick();
        wb = '0;
    endtask

    `include "dispatch_tests.svh"

    initial begin
        #(TIMEOUT);
        $display("timeout: tests still running after %0d time units", TIMEOUT);
        $display("Regression failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        void'($urandom(32'hc7aa));
        cur_test = "reset";
        nRST     = 1'b0;
        idle_inputs();
        repeat (RESET_CYCLES) @(posedge CLK);
        #1;
        nRST = 1'b1;

        reset_and_bubble();
        scalar_decode();
        matrix_decode();
        tag_tracking();
        hazard_stall();
        flush_and_freeze();

        tick();
        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire
